// File: tb.f
xt_bus_pkg.sv
xt_hb_arbiter.sv
xt_mmio.sv
xt_hb.sv
xt_hb_ram.sv
xt_hb_fifo_dev.sv
xt_hb_top.sv
tb_xt_hb.sv

// File: tb_xt_hb.sv
// ######################################
// testbench for the high-speed bus top level
// two master driver tasks reach the scratch
// RAM and the word FIFO; byte mirror of the
// RAM and queue mirror of the FIFO give the
// expected data, assertions do the checking
// ######################################
`timescale 1ns/1ps

module tb_xt_hb;

  import xt_bus_pkg::*;

  localparam int          ram_latency = 2;
  localparam int          fifo_depth  = 4;
  localparam int          wait_limit  = 100;
  localparam logic [31:0] fifo_base   = 32'h1000_0000;

  logic        clk;
  logic        reset;
  logic [1:0]  master_read;
  logic [1:0]  master_write;
  logic [31:0] master_raddr [2];
  logic [31:0] master_waddr [2];
  logic [31:0] master_wdata [2];
  width_t      master_write_width [2];
  logic [1:0]  read_grant;
  logic [1:0]  write_grant;
  logic [1:0]  stall_req;
  logic [31:0] hb_rdata;

  integer      seed;
  int          pass_count;
  int          fail_count;
  logic [7:0]  ram_mirror [1024];
  logic [31:0] fifo_q [$];
  logic [31:0] written [$];
  int          served_order [$];
  int          served_streak [2];
  event        abort_run;

  xt_hb_top #(
    .device_base_addr (fifo_base),
    .ram_latency      (ram_latency),
    .fifo_depth       (fifo_depth)
  ) dut (
    .clk                (clk),
    .reset              (reset),
    .master_read        (master_read),
    .master_write       (master_write),
    .master_raddr       (master_raddr),
    .master_waddr       (master_waddr),
    .master_wdata       (master_wdata),
    .master_write_width (master_write_width),
    .read_grant         (read_grant),
    .write_grant        (write_grant),
    .stall_req          (stall_req),
    .hb_rdata           (hb_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // a timed-out wait ends the run here
  initial begin
    @(abort_run);
    $display("Simulation FAILED");
    $finish;
  end

  // read completions of each master while the other waits for its grant
  always @(posedge clk) begin
    if (reset) begin
      served_streak[0] <= 0;
      served_streak[1] <= 0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!(master_read[1-i] && !read_grant[1-i])) begin
          served_streak[i] <= 0;
        end else if (master_read[i] && read_grant[i] && !stall_req[i]) begin
          served_streak[i] <= served_streak[i] + 1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) $onehot0(read_grant))
    else begin
      $display("read grant has more than one master set");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset) $onehot0(write_grant))
    else begin
      $display("write grant has more than one master set");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
    (read_grant & ~$past(read_grant) & ~$past(master_read)) == 2'b00)
    else begin
      $display("read grant went to a master without a request");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
    (write_grant & ~$past(write_grant) & ~$past(master_write)) == 2'b00)
    else begin
      $display("write grant went to a master without a request");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
    served_streak[0] < 2 && served_streak[1] < 2)
    else begin
      $display("read arbiter served one master twice while the other waited");
      fail_count++;
    end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      $display("FAILED %s expected %08h actual %08h", name, expected, actual);
      fail_count++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    assert (cond) begin
      pass_count++;
    end else begin
      $display("%s", msg);
      fail_count++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    if (fail_count == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failed checks", name, fail_count - start);
    end
  endtask

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  // counts stalled cycles up to the first one with stall_req low
  task automatic wait_for_completion(input int m, input string what, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (stall_req[m] && cycles < wait_limit) begin
      cycles++;
      @(negedge clk);
    end
    if (stall_req[m]) begin
      $display("master %0d timed out waiting on %s", m, what);
      -> abort_run;
    end
  endtask

  task automatic master_read_op(input int m, input logic [31:0] addr,
                                output logic [31:0] data, output int cycles);
    @(posedge clk);
    master_read[m]  <= 1'b1;
    master_raddr[m] <= addr;
    wait_for_completion(m, $sformatf("a read of %08h", addr), cycles);
    data = hb_rdata;
    @(posedge clk);
    master_read[m] <= 1'b0;
  endtask

  task automatic master_write_op(input int m, input logic [31:0] addr,
                                 input logic [31:0] data, input width_t width,
                                 output int cycles);
    @(posedge clk);
    master_write[m]       <= 1'b1;
    master_waddr[m]       <= addr;
    master_wdata[m]       <= data;
    master_write_width[m] <= width;
    wait_for_completion(m, $sformatf("a write to %08h", addr), cycles);
    @(posedge clk);
    master_write[m] <= 1'b0;
  endtask

  // little-endian byte lanes, data right-justified
  function automatic void mirror_store(input logic [31:0] addr, input logic [31:0] data,
                                       input width_t width);
    int a;
    a = int'(addr[9:0]);
    case (width)
      width_byte: ram_mirror[a] = data[7:0];
      width_half: begin
        a = a & ~1;
        ram_mirror[a]   = data[7:0];
        ram_mirror[a+1] = data[15:8];
      end
      default: begin
        a = a & ~3;
        for (int b = 0; b < 4; b++) begin
          ram_mirror[a+b] = data[8*b +: 8];
        end
      end
    endcase
  endfunction

  function automatic logic [31:0] mirror_word(input logic [31:0] addr);
    int a;
    a = int'({addr[9:2], 2'b00});
    return {ram_mirror[a+3], ram_mirror[a+2], ram_mirror[a+1], ram_mirror[a]};
  endfunction

  initial begin : run_tests
    int          start;
    int          rd_cycles;
    int          wr_cycles;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd_data;
    time         pop_time;
    time         push_time;
    seed         = 32'h59da_fe1f;
    pass_count   = 0;
    fail_count   = 0;
    reset        = 1'b1;
    master_read  = '0;
    master_write = '0;
    for (int m = 0; m < 2; m++) begin
      master_raddr[m]       = '0;
      master_waddr[m]       = '0;
      master_wdata[m]       = '0;
      master_write_width[m] = width_word;
    end
    apply_reset();

    start = fail_count;
    @(negedge clk);
    compare_value("read_grant", 32'h0, read_grant);
    compare_value("write_grant", 32'h0, write_grant);
    compare_value("stall_req", 32'h0, stall_req);
    report_test("0 reset state", start);

    // word writes by alternating masters, then read back
    start = fail_count;
    for (int n = 0; n < 8; n++) begin
      addr = $random(seed) & 32'h0000_03fc;
      data = $random(seed);
      master_write_op(n % 2, addr, data, width_word, wr_cycles);
      mirror_store(addr, data, width_word);
      written.push_back(addr);
      compare_value("ram write cycles", 32'd2, wr_cycles);
    end
    for (int n = 0; n < 8; n++) begin
      master_read_op((n + 1) % 2, written[n], rd_data, rd_cycles);
      compare_value("hb_rdata", mirror_word(written[n]), rd_data);
      compare_value("ram read cycles", ram_latency + 1, rd_cycles);
    end
    report_test("1 ram word access", start);

    start = fail_count;
    for (int n = 0; n < 4; n++) begin
      addr = written[n] + ($random(seed) & 3);
      data = $random(seed);
      master_write_op(0, addr, data, width_byte, wr_cycles);
      mirror_store(addr, data, width_byte);
      addr = written[n] + ($random(seed) & 2);
      data = $random(seed);
      master_write_op(1, addr, data, width_half, wr_cycles);
      mirror_store(addr, data, width_half);
      master_read_op(n % 2, written[n], rd_data, rd_cycles);
      compare_value("hb_rdata", mirror_word(written[n]), rd_data);
    end
    report_test("2 width handling", start);

    // RAM read on master 0 alongside FIFO write on master 1
    start = fail_count;
    for (int n = 0; n < 3; n++) begin
      data = $random(seed);
      fork
        master_read_op(0, written[n], rd_data, rd_cycles);
        master_write_op(1, fifo_base, data, width_word, wr_cycles);
      join
      fifo_q.push_back(data);
      compare_value("hb_rdata", mirror_word(written[n]), rd_data);
      compare_value("duplex read cycles", ram_latency + 1, rd_cycles);
      compare_value("duplex fifo write cycles", 32'd1, wr_cycles);
    end
    report_test("3 full duplex", start);

    // fresh arbiter pointer, empty FIFO
    apply_reset();
    fifo_q.delete();
    start = fail_count;
    fork
      begin
        logic [31:0] d0;
        int          c0;
        for (int k = 0; k < 4; k++) begin
          master_read_op(0, written[k], d0, c0);
          served_order.push_back(0);
          compare_value("hb_rdata", mirror_word(written[k]), d0);
        end
      end
      begin
        logic [31:0] d1;
        int          c1;
        for (int k = 0; k < 4; k++) begin
          master_read_op(1, written[k+4], d1, c1);
          served_order.push_back(1);
          compare_value("hb_rdata", mirror_word(written[k+4]), d1);
        end
      end
    join
    for (int k = 0; k < 8; k++) begin
      compare_value("served master", k % 2, served_order[k]);
    end
    report_test("4 arbitration fairness", start);

    start = fail_count;
    fork
      master_read_op(0, fifo_base, rd_data, rd_cycles);
      begin
        repeat (4) @(posedge clk);
        data = $random(seed);
        master_write_op(1, fifo_base, data, width_word, wr_cycles);
        fifo_q.push_back(data);
      end
    join
    expect_true(rd_cycles > 4, "read of the empty FIFO finished before any write");
    compare_value("hb_rdata", fifo_q.pop_front(), rd_data);
    fork
      begin
        for (int k = 0; k <= fifo_depth; k++) begin
          data = $random(seed);
          master_write_op(1, fifo_base, data, width_word, wr_cycles);
          fifo_q.push_back(data);
          if (k < fifo_depth) begin
            compare_value("fifo write cycles", 32'd1, wr_cycles);
          end
        end
        push_time = $time;
      end
      begin
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(fifo_q.size() == fifo_depth && master_write[1] && stall_req[1])
               && waited < wait_limit) begin
          waited++;
          @(negedge clk);
        end
        if (waited >= wait_limit) begin
          $display("master 0 timed out waiting on master 1 to fill the FIFO");
          -> abort_run;
        end
        repeat (3) @(negedge clk);
        expect_true(stall_req[1], "write to the full FIFO was not stalled");
        master_read_op(0, fifo_base, rd_data, rd_cycles);
        pop_time = $time;
        compare_value("hb_rdata", fifo_q.pop_front(), rd_data);
      end
    join
    expect_true(push_time > pop_time, "write to the full FIFO finished before the pop");
    // drain in write order
    for (int k = 0; k < fifo_depth; k++) begin
      master_read_op(0, fifo_base, rd_data, rd_cycles);
      compare_value("hb_rdata", fifo_q.pop_front(), rd_data);
    end
    report_test("5 fifo back-pressure", start);

    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: xt_bus_pkg.sv
// ######################################
// shared definitions of the high-speed bus
// address and device identifier widths,
// the write-width opcode and the RAM read
// sequencer states; import where needed
// ######################################
package xt_bus_pkg;

  // byte address seen by masters and devices
  localparam int hb_addr_width = 32;

  // top address bits that name a device
  localparam int hb_id_width = 4;

  // store width presented with a write request
  typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_half = 2'd1,
    width_word = 2'd2
  } width_t;

  // scratch RAM read sequencer
  typedef enum logic {
    ram_idle = 1'b0,
    ram_busy = 1'b1
  } ram_state_t;

endpackage

// File: xt_hb.sv
// ######################################
// high-speed bus controller
// independent read and write channels, each
// with its own round-robin arbiter; routes
// the granted master to the decoded device
// and stalls masters until their finish
// ######################################
`timescale 1ns/1ps

module xt_hb #(
  parameter int master_num = 2,
  parameter int device_num = 2,
  parameter logic [device_num-1:1][xt_bus_pkg::hb_addr_width-1:0] device_base_addr = '0
) (
  input  logic                                 clk,
  input  logic                                 reset,
  // master side
  input  logic [master_num-1:0]                master_read,
  input  logic [master_num-1:0]                master_write,
  input  logic [xt_bus_pkg::hb_addr_width-1:0] master_raddr       [master_num],
  input  logic [xt_bus_pkg::hb_addr_width-1:0] master_waddr       [master_num],
  input  logic [31:0]                          master_wdata       [master_num],
  input  xt_bus_pkg::width_t                   master_write_width [master_num],
  // device side
  input  logic [31:0]                          dev_rdata          [device_num],
  input  logic [device_num-1:0]                read_finish,
  input  logic [device_num-1:0]                write_finish,
  // shared read data, valid for the read-granted master
  output logic [31:0]                          hb_rdata,
  output logic [xt_bus_pkg::hb_addr_width-1:0] bus_raddr,
  output logic [xt_bus_pkg::hb_addr_width-1:0] bus_waddr,
  output logic [31:0]                          bus_wdata,
  output xt_bus_pkg::width_t                   bus_write_width,
  output logic [device_num-1:0]                dev_ren,
  output logic [device_num-1:0]                dev_wen,
  output logic [master_num-1:0]                read_grant,
  output logic [master_num-1:0]                write_grant,
  output logic [master_num-1:0]                stall_req
);

  import xt_bus_pkg::*;

  logic                  read_busy;
  logic                  write_busy;
  logic                  hb_ren;
  logic                  hb_wen;
  logic                  read_stall;
  logic                  write_stall;
  logic [master_num-1:0] arbiter_stall;

  logic [hb_addr_width-1:0] dec_addr [2];
  logic [device_num-1:0]    dec_sel  [2];

  xt_hb_arbiter #(.master_num(master_num)) u_read_arbiter (
    .clk   (clk),
    .reset (reset),
    .req   (master_read),
    .grant (read_grant),
    .busy  (read_busy)
  );

  xt_hb_arbiter #(.master_num(master_num)) u_write_arbiter (
    .clk   (clk),
    .reset (reset),
    .req   (master_write),
    .grant (write_grant),
    .busy  (write_busy)
  );

  // channel is active only while its owner still requests
  assign hb_ren = read_busy & |(master_read & read_grant);
  assign hb_wen = write_busy & |(master_write & write_grant);

  // granted master onto each channel, grants are one-hot
  always_comb begin
    bus_raddr       = '0;
    bus_waddr       = '0;
    bus_wdata       = '0;
    bus_write_width = width_word;
    for (int i = 0; i < master_num; i++) begin
      if (read_grant[i]) begin
        bus_raddr = master_raddr[i];
      end
      if (write_grant[i]) begin
        bus_waddr       = master_waddr[i];
        bus_wdata       = master_wdata[i];
        bus_write_width = master_write_width[i];
      end
    end
  end

  assign dec_addr[0] = bus_raddr;
  assign dec_addr[1] = bus_waddr;

  xt_mmio #(
    .addr_num         (2),
    .device_num       (device_num),
    .device_base_addr (device_base_addr)
  ) u_mmio (
    .addr (dec_addr),
    .sel  (dec_sel)
  );

  assign dev_ren = hb_ren ? dec_sel[0] : '0;
  assign dev_wen = hb_wen ? dec_sel[1] : '0;

  always_comb begin
    hb_rdata = '0;
    for (int i = 0; i < device_num; i++) begin
      hb_rdata = hb_rdata | ({32{dev_ren[i]}} & dev_rdata[i]);
    end
  end

  // active channel waits for its selected device
  assign read_stall  = hb_ren && ((read_finish & dev_ren) == '0);
  assign write_stall = hb_wen && ((write_finish & dev_wen) == '0);

  assign arbiter_stall = (master_read & ~read_grant) | (master_write & ~write_grant);

  always_comb begin
    for (int i = 0; i < master_num; i++) begin
      stall_req[i] = arbiter_stall[i]
                   | (master_read[i] & read_grant[i] & read_stall)
                   | (master_write[i] & write_grant[i] & write_stall);
    end
  end

endmodule

// File: xt_hb_arbiter.sv
// ######################################
// round-robin arbiter for one bus channel
// registered one-hot grant, locked to its
// owner while the owner keeps requesting
// ######################################
`timescale 1ns/1ps

module xt_hb_arbiter #(
  parameter int master_num = 2
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [master_num-1:0] req,
  output logic [master_num-1:0] grant,
  output logic                  busy
);

  localparam int ptr_w = (master_num > 1) ? $clog2(master_num) : 1;

  logic [ptr_w-1:0]      ptr;
  logic [ptr_w-1:0]      next_ptr;
  logic [master_num-1:0] next_grant;
  logic                  hold;

  // owner still requesting, keep the grant
  assign hold = |(grant & req);
  assign busy = |grant;

  always_comb begin
    int idx;
    idx        = 0;
    next_grant = grant;
    next_ptr   = ptr;
    if (!hold) begin
      next_grant = '0;
      // walk down so the requester closest to ptr wins last
      for (int k = master_num - 1; k >= 0; k--) begin
        idx = (int'(ptr) + k) % master_num;
        if (req[idx]) begin
          next_grant      = '0;
          next_grant[idx] = 1'b1;
          next_ptr        = ptr_w'((idx + 1) % master_num);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= '0;
      ptr   <= '0;
    end else begin
      grant <= next_grant;
      // pointer moves past each newly served master
      if (!hold && |next_grant) begin
        ptr <= next_ptr;
      end
    end
  end

endmodule

// File: xt_hb_fifo_dev.sv
// ######################################
// word FIFO device on the bus
// a write finishes only when there is room
// and a read only when a word is held, so
// the bus stalls writers and readers
// ######################################
`timescale 1ns/1ps

module xt_hb_fifo_dev #(
  parameter int fifo_depth = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        ren,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic        read_finish,
  output logic        write_finish
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  logic [31:0]      mem [fifo_depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             empty;

  assign full  = (count == cnt_w'(fifo_depth));
  assign empty = (count == '0);

  assign write_finish = wen && !full;
  assign read_finish  = ren && !empty;
  // head word
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (write_finish) begin
        wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (read_finish) begin
        rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({write_finish, read_finish})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_finish) begin
      mem[wr_ptr] <= wdata;
    end
  end

endmodule

// File: xt_hb_ram.sv
// ######################################
// scratch RAM device on the bus
// reads finish a fixed number of cycles
// after ren rises; byte, half and word
// writes finish the cycle after wen
// ######################################
`timescale 1ns/1ps

module xt_hb_ram #(
  parameter int ram_words   = 256,
  parameter int ram_latency = 2
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 ren,
  input  logic                                 wen,
  input  logic [xt_bus_pkg::hb_addr_width-1:0] raddr,
  input  logic [xt_bus_pkg::hb_addr_width-1:0] waddr,
  input  logic [31:0]                          wdata,
  input  xt_bus_pkg::width_t                   write_width,
  output logic [31:0]                          rdata,
  output logic                                 read_finish,
  output logic                                 write_finish
);

  import xt_bus_pkg::*;

  localparam int idx_w = $clog2(ram_words);
  localparam int cnt_w = $clog2(ram_latency + 1);

  logic [3:0][7:0] mem [ram_words];

  ram_state_t       state;
  logic [cnt_w-1:0] cnt;
  logic             read_start;
  logic             read_done;
  logic [3:0]       byte_en;
  logic [31:0]      lane_data;

  // no new read in the finish cycle, ren there still belongs to the old one
  assign read_start = (state == ram_idle) && ren && !read_finish;
  assign read_done  = ren && (((state == ram_busy) && (cnt == cnt_w'(ram_latency - 1)))
                            || (read_start && (ram_latency == 1)));

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= ram_idle;
      cnt          <= '0;
      read_finish  <= 1'b0;
      write_finish <= 1'b0;
    end else begin
      read_finish  <= read_done;
      // one finish pulse per write, even with wen held
      write_finish <= wen & ~write_finish;
      case (state)
        ram_idle: begin
          if (read_start && !read_done) begin
            state <= ram_busy;
            cnt   <= cnt_w'(1);
          end
        end
        ram_busy: begin
          if (!ren || read_done) begin
            state <= ram_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= ram_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (read_done) begin
      rdata <= mem[raddr[idx_w+1:2]];
    end
  end

  // store data is right-justified, replicate it onto every lane
  always_comb begin
    case (write_width)
      width_byte: begin
        byte_en   = 4'b0001 << waddr[1:0];
        lane_data = {4{wdata[7:0]}};
      end
      width_half: begin
        byte_en   = 4'b0011 << {waddr[1], 1'b0};
        lane_data = {2{wdata[15:0]}};
      end
      default: begin
        byte_en   = 4'b1111;
        lane_data = wdata;
      end
    endcase
  end

  // commit at the edge that ends the finish cycle
  always_ff @(posedge clk) begin
    if (wen && write_finish) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) begin
          mem[waddr[idx_w+1:2]][b] <= lane_data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: xt_hb_top.sv
// ######################################
// top level of the bus subsystem
// two masters reach the scratch RAM
// (device 0) and the word FIFO (device 1)
// through one bus controller
// ######################################
`timescale 1ns/1ps

module xt_hb_top #(
  parameter int master_num  = 2,
  parameter int device_num  = 2,
  parameter logic [device_num-1:1][xt_bus_pkg::hb_addr_width-1:0] device_base_addr =
    32'h1000_0000,
  parameter int ram_words   = 256,
  parameter int ram_latency = 2,
  parameter int fifo_depth  = 4
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [master_num-1:0]                master_read,
  input  logic [master_num-1:0]                master_write,
  input  logic [xt_bus_pkg::hb_addr_width-1:0] master_raddr       [master_num],
  input  logic [xt_bus_pkg::hb_addr_width-1:0] master_waddr       [master_num],
  input  logic [31:0]                          master_wdata       [master_num],
  input  xt_bus_pkg::width_t                   master_write_width [master_num],
  output logic [master_num-1:0]                read_grant,
  output logic [master_num-1:0]                write_grant,
  output logic [master_num-1:0]                stall_req,
  output logic [31:0]                          hb_rdata
);

  import xt_bus_pkg::*;

  logic [hb_addr_width-1:0] bus_raddr;
  logic [hb_addr_width-1:0] bus_waddr;
  logic [31:0]              bus_wdata;
  width_t                   bus_write_width;
  logic [device_num-1:0]    dev_ren;
  logic [device_num-1:0]    dev_wen;
  logic [31:0]              dev_rdata [device_num];
  logic [device_num-1:0]    read_finish;
  logic [device_num-1:0]    write_finish;

  xt_hb #(
    .master_num       (master_num),
    .device_num       (device_num),
    .device_base_addr (device_base_addr)
  ) u_hb (
    .clk                (clk),
    .reset              (reset),
    .master_read        (master_read),
    .master_write       (master_write),
    .master_raddr       (master_raddr),
    .master_waddr       (master_waddr),
    .master_wdata       (master_wdata),
    .master_write_width (master_write_width),
    .dev_rdata          (dev_rdata),
    .read_finish        (read_finish),
    .write_finish       (write_finish),
    .hb_rdata           (hb_rdata),
    .bus_raddr          (bus_raddr),
    .bus_waddr          (bus_waddr),
    .bus_wdata          (bus_wdata),
    .bus_write_width    (bus_write_width),
    .dev_ren            (dev_ren),
    .dev_wen            (dev_wen),
    .read_grant         (read_grant),
    .write_grant        (write_grant),
    .stall_req          (stall_req)
  );

  // device 0, scratch RAM from address zero
  xt_hb_ram #(
    .ram_words   (ram_words),
    .ram_latency (ram_latency)
  ) u_ram (
    .clk          (clk),
    .reset        (reset),
    .ren          (dev_ren[0]),
    .wen          (dev_wen[0]),
    .raddr        (bus_raddr),
    .waddr        (bus_waddr),
    .wdata        (bus_wdata),
    .write_width  (bus_write_width),
    .rdata        (dev_rdata[0]),
    .read_finish  (read_finish[0]),
    .write_finish (write_finish[0])
  );

  // device 1, word FIFO, address and width not needed
  xt_hb_fifo_dev #(.fifo_depth(fifo_depth)) u_fifo (
    .clk          (clk),
    .reset        (reset),
    .ren          (dev_ren[1]),
    .wen          (dev_wen[1]),
    .wdata        (bus_wdata),
    .rdata        (dev_rdata[1]),
    .read_finish  (read_finish[1]),
    .write_finish (write_finish[1])
  );

endmodule

// File: xt_mmio.sv
// ######################################
// memory-mapped address decoder
// turns each address into a one-hot device
// select by comparing the identifier bits
// with the per-device base list
// ######################################
`timescale 1ns/1ps

module xt_mmio #(
  parameter int addr_num   = 2,
  parameter int device_num = 2,
  // bases of devices 1 and up, aligned on the identifier bits
  parameter logic [device_num-1:1][xt_bus_pkg::hb_addr_width-1:0] device_base_addr = '0
) (
  input  logic [xt_bus_pkg::hb_addr_width-1:0] addr [addr_num],
  output logic [device_num-1:0]                sel  [addr_num]
);

  import xt_bus_pkg::*;

  localparam int id_lsb = hb_addr_width - hb_id_width;

  always_comb begin
    int idx;
    idx = 0;
    for (int a = 0; a < addr_num; a++) begin
      // device 0 owns the space from zero
      idx = 0;
      for (int d = 1; d < device_num; d++) begin
        if (addr[a][hb_addr_width-1:id_lsb] >= device_base_addr[d][hb_addr_width-1:id_lsb]) begin
          idx = d;
        end
      end
      sel[a]      = '0;
      sel[a][idx] = 1'b1;
    end
  end

endmodule
